// ==== dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address and data widths
`define DC_ADDR_W    32
`define DC_XLEN      64
`define DC_LINE_W    256

// two ways of 64 sets, 32-byte lines
`define DC_SETS      64
`define DC_INDEX_W   6
`define DC_TAG_W     21

// refill beats per line
`define DC_BEATS     4

// victim lfsr start value, must be nonzero
`define DC_LFSR_SEED 16'hace1

`endif

// ==== dcachePkg.sv ====
`default_nettype none

package dcachePkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    COMPARE = 3'd1,
    WRBACK  = 3'd2,
    MISS    = 3'd3,
    GETDATA = 3'd4,
    REPLACE = 3'd5
  } cacheState_e;

  // cpu request operation
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } memOp_e;

endpackage

`default_nettype wire

// ==== dataArrayIf.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

interface dataArrayIf;

  logic [`DC_INDEX_W-1:0] index;
  logic [1:0]             wayWe;
  logic [`DC_LINE_W-1:0]  wrLine;
  logic [`DC_LINE_W/8-1:0] byteMask;
  // registered, one cycle after index
  logic [`DC_LINE_W-1:0]  rdLineWay0;
  logic [`DC_LINE_W-1:0]  rdLineWay1;

  modport ctrl (
    output index, wayWe, wrLine, byteMask,
    input  rdLineWay0, rdLineWay1
  );

  modport array (
    input  index, wayWe, wrLine, byteMask,
    output rdLineWay0, rdLineWay1
  );

  // passive view for probing
  modport monitor (
    input index, wayWe, wrLine, byteMask, rdLineWay0, rdLineWay1
  );

endinterface

`default_nettype wire

// ==== sramBank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module sramBank (
  input  wire logic                     clk,
  input  wire logic                     we_i,
  input  wire logic [`DC_INDEX_W-1:0]   addr_i,
  input  wire logic [`DC_LINE_W/2-1:0]  wrData_i,
  input  wire logic [`DC_LINE_W/16-1:0] byteEn_i,
  output logic [`DC_LINE_W/2-1:0]       rdData_o
);

  localparam int BYTES = `DC_LINE_W / 16;

  logic [`DC_LINE_W/2-1:0] mem [`DC_SETS];

  // read every cycle, old data on a same-address write
  always_ff @(posedge clk) begin
    rdData_o <= mem[addr_i];
    if (we_i) begin
      for (int b = 0; b < BYTES; b++) begin
        if (byteEn_i[b]) begin
          mem[addr_i][b*8 +: 8] <= wrData_i[b*8 +: 8];
        end
      end
    end
  end

  // a write to an unknown row would corrupt the whole bank in silicon
  aWrAddrKnown: assert property (
    @(posedge clk) we_i |-> !$isunknown(addr_i)
  ) else $error("sramBank write with unknown address");

endmodule

`default_nettype wire

// ==== dcacheDataArray.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module dcacheDataArray (
  input  wire logic clk,
  dataArrayIf.array arr
);

  localparam int HALF_W = `DC_LINE_W / 2;
  localparam int HALF_B = HALF_W / 8;

  logic [1:0][`DC_LINE_W-1:0] rdLine;

  // each way is a low and a high 128-bit bank sharing one index
  for (genvar w = 0; w < 2; w++) begin : gWay
    for (genvar h = 0; h < 2; h++) begin : gHalf
      sramBank uBank (
        .clk      (clk),
        .we_i     (arr.wayWe[w]),
        .addr_i   (arr.index),
        .wrData_i (arr.wrLine[h*HALF_W +: HALF_W]),
        .byteEn_i (arr.byteMask[h*HALF_B +: HALF_B]),
        .rdData_o (rdLine[w][h*HALF_W +: HALF_W])
      );
    end
  end

  assign arr.rdLineWay0 = rdLine[0];
  assign arr.rdLineWay1 = rdLine[1];

endmodule

`default_nettype wire

// ==== dcacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module dcacheCtrl (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   reqValid_i,
  input  wire dcachePkg::memOp_e      reqOp_i,
  input  wire logic [`DC_ADDR_W-1:0]  reqAddr_i,
  input  wire logic [`DC_XLEN-1:0]    wrData_i,
  input  wire logic [`DC_XLEN/8-1:0]  wrMask_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [`DC_XLEN-1:0]         rdData_o,
  output logic                        memRdValid_o,
  input  wire logic                   memRdReady_i,
  output logic [`DC_ADDR_W-1:0]       memRdAddr_o,
  input  wire logic [`DC_XLEN-1:0]    memRdData_i,
  input  wire logic                   memRdDataValid_i,
  input  wire logic                   memRdLast_i,
  output logic                        memWrValid_o,
  input  wire logic                   memWrReady_i,
  output logic [`DC_ADDR_W-1:0]       memWrAddr_o,
  output logic [`DC_LINE_W-1:0]       memWrData_o,
  dataArrayIf.ctrl                    arr
);

  localparam int OFF_W  = `DC_ADDR_W - `DC_TAG_W - `DC_INDEX_W;
  localparam int BEAT_W = $clog2(`DC_BEATS);

  dcachePkg::cacheState_e state, nextState;

  dcachePkg::memOp_e      reqOpQ;
  logic [`DC_ADDR_W-1:0]  reqAddrQ;
  logic [`DC_XLEN-1:0]    wrDataQ;
  logic [`DC_XLEN/8-1:0]  wrMaskQ;
  logic [`DC_TAG_W-1:0]   reqTag;
  logic [`DC_INDEX_W-1:0] reqIndex;
  logic [BEAT_W-1:0]      wordSel;

  logic [`DC_SETS-1:0]    validArr [2];
  logic [`DC_SETS-1:0]    dirtyArr [2];
  logic [`DC_TAG_W-1:0]   tagArr [2][`DC_SETS];

  logic [1:0]             wayHit;
  logic                   cacheHit;
  logic                   isStore;
  logic                   accept;
  logic [15:0]            lfsr;
  logic                   victimSel;
  logic                   victimWay;
  logic [`DC_LINE_W-1:0]  refillBuf;
  logic [BEAT_W-1:0]      beatCnt;
  logic                   fromRefill;
  logic [`DC_LINE_W-1:0]  hitLine;

  assign reqTag   = reqAddrQ[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign reqIndex = reqAddrQ[OFF_W +: `DC_INDEX_W];
  // word within the line, address bits 4:3
  assign wordSel  = reqAddrQ[OFF_W-1 -: BEAT_W];
  assign isStore  = (reqOpQ == dcachePkg::OP_STORE);

  for (genvar w = 0; w < 2; w++) begin : gHit
    assign wayHit[w] = validArr[w][reqIndex] && (tagArr[w][reqIndex] == reqTag);
  end
  assign cacheHit = |wayHit;

  // only a load hit lets the next request in during compare
  assign addrOk_o = (state == dcachePkg::IDLE) ||
                    (state == dcachePkg::COMPARE && cacheHit && !isStore);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = (state == dcachePkg::COMPARE) && cacheHit;

  // just-refilled line is not yet readable from the banks
  assign hitLine  = fromRefill ? refillBuf :
                    (wayHit[1] ? arr.rdLineWay1 : arr.rdLineWay0);
  assign rdData_o = hitLine[wordSel*`DC_XLEN +: `DC_XLEN];

  // invalid way first, else pseudo-random
  assign victimSel = !validArr[0][reqIndex] ? 1'b0 :
                     !validArr[1][reqIndex] ? 1'b1 : lfsr[0];

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::IDLE: begin
        if (accept) begin
          nextState = dcachePkg::COMPARE;
        end
      end
      dcachePkg::COMPARE: begin
        if (cacheHit) begin
          nextState = accept ? dcachePkg::COMPARE : dcachePkg::IDLE;
        end else if (dirtyArr[victimSel][reqIndex]) begin
          nextState = dcachePkg::WRBACK;
        end else begin
          nextState = dcachePkg::MISS;
        end
      end
      dcachePkg::WRBACK: begin
        if (memWrReady_i) begin
          nextState = dcachePkg::MISS;
        end
      end
      dcachePkg::MISS: begin
        if (memRdReady_i) begin
          nextState = dcachePkg::GETDATA;
        end
      end
      dcachePkg::GETDATA: begin
        if (memRdDataValid_i && memRdLast_i) begin
          nextState = dcachePkg::REPLACE;
        end
      end
      dcachePkg::REPLACE: nextState = dcachePkg::COMPARE;
      default: nextState = dcachePkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= dcachePkg::IDLE;
      reqOpQ     <= dcachePkg::OP_LOAD;
      reqAddrQ   <= '0;
      lfsr       <= `DC_LFSR_SEED;
      victimWay  <= 1'b0;
      beatCnt    <= '0;
      fromRefill <= 1'b0;
    end else begin
      state      <= nextState;
      fromRefill <= (state == dcachePkg::REPLACE);
      if (accept) begin
        reqOpQ   <= reqOp_i;
        reqAddrQ <= reqAddr_i;
      end
      // taps 16,14,13,11, one step per miss
      if (state == dcachePkg::COMPARE && !cacheHit) begin
        lfsr      <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        victimWay <= victimSel;
      end
      if (state == dcachePkg::GETDATA && memRdDataValid_i) begin
        beatCnt <= memRdLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wrDataQ <= wrData_i;
      wrMaskQ <= wrMask_i;
    end
    if (state == dcachePkg::GETDATA && memRdDataValid_i) begin
      refillBuf[beatCnt*`DC_XLEN +: `DC_XLEN] <= memRdData_i;
    end
    if (state == dcachePkg::REPLACE) begin
      tagArr[victimWay][reqIndex] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '{default: '0};
      dirtyArr <= '{default: '0};
    end else if (state == dcachePkg::REPLACE) begin
      validArr[victimWay][reqIndex] <= 1'b1;
      dirtyArr[victimWay][reqIndex] <= 1'b0;
    end else if (dataOk_o && isStore) begin
      dirtyArr[wayHit[1]][reqIndex] <= 1'b1;
    end
  end

  // live index on acceptance so the banks answer in compare
  assign arr.index = accept ? reqAddr_i[OFF_W +: `DC_INDEX_W] : reqIndex;

  always_comb begin
    arr.wayWe    = 2'b00;
    arr.wrLine   = {`DC_BEATS{wrDataQ}};
    arr.byteMask = {{(`DC_LINE_W/8 - `DC_XLEN/8){1'b0}}, wrMaskQ}
                   << (wordSel * (`DC_XLEN/8));
    if (state == dcachePkg::REPLACE) begin
      arr.wayWe    = {victimWay, !victimWay};
      arr.wrLine   = refillBuf;
      arr.byteMask = '1;
    end else if (dataOk_o && isStore) begin
      arr.wayWe = wayHit;
    end
  end

  assign memWrValid_o = (state == dcachePkg::WRBACK);
  assign memRdValid_o = (state == dcachePkg::MISS);
  assign memRdAddr_o  = {reqTag, reqIndex, {OFF_W{1'b0}}};
  assign memWrAddr_o  = {tagArr[victimWay][reqIndex], reqIndex, {OFF_W{1'b0}}};
  // banks keep re-reading the latched index, so the victim line stays put
  assign memWrData_o  = victimWay ? arr.rdLineWay1 : arr.rdLineWay0;

  aWayWeOneHot: assert property (
    @(posedge clk) disable iff (!rst_n) !(&arr.wayWe)
  ) else $error("both ways written in one cycle");

  aMemExclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(memRdValid_o && memWrValid_o)
  ) else $error("read and write request raised together");

  // a set never holds the same tag in both ways
  aHitUnique: assert property (
    @(posedge clk) disable iff (!rst_n) dataOk_o |-> $onehot(wayHit)
  ) else $error("dataOk without a unique tag match");

endmodule

`default_nettype wire

// ==== dcacheTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module dcacheTop (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // cpu side
  input  wire logic                   reqValid_i,
  input  wire dcachePkg::memOp_e      reqOp_i,
  input  wire logic [`DC_ADDR_W-1:0]  reqAddr_i,
  input  wire logic [`DC_XLEN-1:0]    wrData_i,
  input  wire logic [`DC_XLEN/8-1:0]  wrMask_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [`DC_XLEN-1:0]         rdData_o,
  // memory side
  output logic                        memRdValid_o,
  input  wire logic                   memRdReady_i,
  output logic [`DC_ADDR_W-1:0]       memRdAddr_o,
  input  wire logic [`DC_XLEN-1:0]    memRdData_i,
  input  wire logic                   memRdDataValid_i,
  input  wire logic                   memRdLast_i,
  output logic                        memWrValid_o,
  input  wire logic                   memWrReady_i,
  output logic [`DC_ADDR_W-1:0]       memWrAddr_o,
  output logic [`DC_LINE_W-1:0]       memWrData_o
);

  dataArrayIf daIf ();

  dcacheCtrl uCtrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .reqOp_i          (reqOp_i),
    .reqAddr_i        (reqAddr_i),
    .wrData_i         (wrData_i),
    .wrMask_i         (wrMask_i),
    .addrOk_o         (addrOk_o),
    .dataOk_o         (dataOk_o),
    .rdData_o         (rdData_o),
    .memRdValid_o     (memRdValid_o),
    .memRdReady_i     (memRdReady_i),
    .memRdAddr_o      (memRdAddr_o),
    .memRdData_i      (memRdData_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrReady_i     (memWrReady_i),
    .memWrAddr_o      (memWrAddr_o),
    .memWrData_o      (memWrData_o),
    .arr              (daIf.ctrl)
  );

  dcacheDataArray uData (
    .clk (clk),
    .arr (daIf.array)
  );

endmodule

`default_nettype wire

// ==== tbDcache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defines.svh"

module tbDcache;

  localparam int NUM_REQ = 27;
  localparam int TIMEOUT = 500;
  localparam logic [63:0] END_OP = 64'hff;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] addr;
    logic [63:0] expData;
    logic [31:0] acceptCycle;
    logic [31:0] rdSnap;
  } pendingReq_t;

  logic                    clk;
  logic                    rst_n;
  logic                    reqValid_i;
  dcachePkg::memOp_e       reqOp_i;
  logic [`DC_ADDR_W-1:0]   reqAddr_i;
  logic [`DC_XLEN-1:0]     wrData_i;
  logic [`DC_XLEN/8-1:0]   wrMask_i;
  logic                    addrOk_o;
  logic                    dataOk_o;
  logic [`DC_XLEN-1:0]     rdData_o;
  logic                    memRdValid_o;
  logic                    memRdReady_i;
  logic [`DC_ADDR_W-1:0]   memRdAddr_o;
  logic [`DC_XLEN-1:0]     memRdData_i;
  logic                    memRdDataValid_i;
  logic                    memRdLast_i;
  logic                    memWrValid_o;
  logic                    memWrReady_i;
  logic [`DC_ADDR_W-1:0]   memWrAddr_o;
  logic [`DC_LINE_W-1:0]   memWrData_o;

  // five words per request: op, address, write data, mask, expected load data
  logic [63:0] stimMem [0:NUM_REQ*5-1];
  logic [63:0] memWords [logic [31:0]];
  pendingReq_t pendQ [$];
  logic [31:0] lfsrState = 32'ha886_49ff;
  logic timedOut = 1'b0;
  int checkCount = 0;
  int errCount = 0;
  int cycle = 0;
  int rdCycles = 0;

  dcacheTop dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .reqOp_i          (reqOp_i),
    .reqAddr_i        (reqAddr_i),
    .wrData_i         (wrData_i),
    .wrMask_i         (wrMask_i),
    .addrOk_o         (addrOk_o),
    .dataOk_o         (dataOk_o),
    .rdData_o         (rdData_o),
    .memRdValid_o     (memRdValid_o),
    .memRdReady_i     (memRdReady_i),
    .memRdAddr_o      (memRdAddr_o),
    .memRdData_i      (memRdData_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrReady_i     (memWrReady_i),
    .memWrAddr_o      (memWrAddr_o),
    .memWrData_o      (memWrData_o)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomBits(input int n, output int value);
    value = 0;
    repeat (n) begin
      lfsrState = lfsrNext(lfsrState);
      value = (value << 1) | lfsrState[0];
    end
  endtask

  // unwritten words read back as their own byte address with a marker on top
  function automatic logic [63:0] readWord(input logic [31:0] addr);
    if (memWords.exists(addr)) begin
      return memWords[addr];
    end else begin
      return {32'h0, addr} ^ 64'h5a5a_0000_0000_0000;
    end
  endfunction

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
    checkCount++;
    assert (got === expected) else begin
      errCount++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    checkCount++;
    assert (cond) else begin
      errCount++;
      $display("Error: %s", what);
    end
  endtask

  task automatic finishRun();
    $display("Summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic failTimeout(input string what);
    errCount++;
    timedOut = 1'b1;
    $display("Timed out waiting for %s", what);
  endtask

  // match each dataOk_o pulse against the oldest accepted request
  task automatic collectResponse();
    pendingReq_t req;
    if (memRdValid_o) begin
      rdCycles++;
    end
    if (dataOk_o) begin
      if (pendQ.size() == 0) begin
        confirm(1'b0, "dataOk_o pulsed with no request outstanding");
      end else begin
        req = pendQ.pop_front();
        if (!req.op[0]) begin
          compareValue($sformatf("rdData_o (addr %h)", req.addr), rdData_o, req.expData);
        end
        if (req.op[1]) begin
          confirm(cycle == req.acceptCycle + 1, "hit did not finish one cycle after acceptance");
          confirm(rdCycles == req.rdSnap, "memory read issued for an expected hit");
        end
      end
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);
    cycle++;
    collectResponse();
  endtask

  task automatic waitAddrOk();
    int waited;
    waited = 0;
    while (!addrOk_o && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (!addrOk_o) failTimeout("addrOk_o to rise");
  endtask

  task automatic waitIdle();
    int waited;
    waited = 0;
    while (pendQ.size() != 0 && waited < TIMEOUT) begin
      nextCycle();
      waited++;
    end
    if (pendQ.size() != 0) failTimeout("outstanding requests to finish");
  endtask

  task automatic serveWrite();
    int delay;
    int beat;
    logic [31:0] base;
    randomBits(2, delay);
    repeat (delay) begin
      @(negedge clk);
      confirm(memWrValid_o, "memWrValid_o dropped before the write was taken");
    end
    base = memWrAddr_o;
    compareValue("memWrAddr_o[4:0]", base[4:0], 64'h0);
    for (beat = 0; beat < `DC_BEATS; beat++) begin
      memWords[base + beat * 8] = memWrData_o[beat*64 +: 64];
    end
    memWrReady_i = 1'b1;
    @(negedge clk);
    memWrReady_i = 1'b0;
  endtask

  task automatic serveRead();
    int delay;
    int beat;
    logic [31:0] base;
    randomBits(2, delay);
    repeat (delay) begin
      @(negedge clk);
      confirm(memRdValid_o, "memRdValid_o dropped before the read was taken");
    end
    base = memRdAddr_o;
    compareValue("memRdAddr_o[4:0]", base[4:0], 64'h0);
    memRdReady_i = 1'b1;
    @(negedge clk);
    memRdReady_i = 1'b0;
    // beats back to back, in word order
    for (beat = 0; beat < `DC_BEATS; beat++) begin
      memRdDataValid_i = 1'b1;
      memRdData_i      = readWord(base + beat * 8);
      memRdLast_i      = (beat == `DC_BEATS - 1);
      @(negedge clk);
    end
    memRdDataValid_i = 1'b0;
    memRdLast_i      = 1'b0;
  endtask

  initial begin : memResponder
    forever begin
      @(negedge clk);
      if (rst_n && memWrValid_o) begin
        serveWrite();
      end else if (rst_n && memRdValid_o) begin
        serveRead();
      end
    end
  end

  initial begin : stimulus
    int idx;
    logic [63:0] op;
    pendingReq_t req;
    rst_n            = 1'b0;
    reqValid_i       = 1'b0;
    reqOp_i          = dcachePkg::OP_LOAD;
    reqAddr_i        = '0;
    wrData_i         = '0;
    wrMask_i         = '0;
    memRdReady_i     = 1'b0;
    memRdData_i      = '0;
    memRdDataValid_i = 1'b0;
    memRdLast_i      = 1'b0;
    memWrReady_i     = 1'b0;
    $readmemh("dcache_stim.txt", stimMem);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    nextCycle();
    confirm(!$isunknown(stimMem[0]), "stimulus file dcache_stim.txt could not be read");
    compareValue("addrOk_o", addrOk_o, 64'h1);
    compareValue("dataOk_o", dataOk_o, 64'h0);
    compareValue("memRdValid_o", memRdValid_o, 64'h0);
    compareValue("memWrValid_o", memWrValid_o, 64'h0);

    // op bit 0 store, bit 1 expect hit, bit 2 issue back to back
    idx = 0;
    while (!timedOut && idx < NUM_REQ && stimMem[idx*5] !== END_OP) begin
      op = stimMem[idx*5];
      if (!op[2]) begin
        reqValid_i = 1'b0;
        waitIdle();
      end else begin
        confirm(addrOk_o, "back-to-back request found addrOk_o low");
      end
      if (!timedOut) begin
        reqValid_i = 1'b1;
        reqOp_i    = op[0] ? dcachePkg::OP_STORE : dcachePkg::OP_LOAD;
        reqAddr_i  = stimMem[idx*5+1][31:0];
        wrData_i   = stimMem[idx*5+2];
        wrMask_i   = stimMem[idx*5+3][7:0];
        waitAddrOk();
        if (!timedOut) begin
          // accepted at the coming rising edge
          req.op          = op[7:0];
          req.addr        = reqAddr_i;
          req.expData     = stimMem[idx*5+4];
          req.acceptCycle = cycle;
          req.rdSnap      = rdCycles;
          pendQ.push_back(req);
          nextCycle();
        end
      end
      idx++;
    end
    reqValid_i = 1'b0;
    if (!timedOut) begin
      waitIdle();
    end
    if (!timedOut) begin
      confirm(idx == NUM_REQ - 1, "stimulus ended before its end marker");
    end
    finishRun();
  end

endmodule

`default_nettype wire

// ==== dcache_stim.txt ====
// op addr wdata mask expected; op bit0 store, bit1 expect hit, bit2 back to back
// unwritten memory words read as 5a5a0000 followed by the word's byte address
0 00001048 0000000000000000 00 5a5a000000001048
2 00001048 0000000000000000 00 5a5a000000001048
6 00001050 0000000000000000 00 5a5a000000001050
6 00001058 0000000000000000 00 5a5a000000001058
6 00001040 0000000000000000 00 5a5a000000001040
1 00002010 1122334455667788 0f 0000000000000000
2 00002010 0000000000000000 00 5a5a000055667788
3 00002018 aabbccddeeff0011 f0 0000000000000000
2 00002018 0000000000000000 00 aabbccdd00002018
3 00002008 0123456789abcdef 3c 0000000000000000
2 00002008 0000000000000000 00 5a5a456789ab2008
1 000080a8 11110000aaaa0001 ff 0000000000000000
1 000100a8 22220000bbbb0002 ff 0000000000000000
1 000180a8 33330000cccc0003 ff 0000000000000000
0 000080a8 0000000000000000 00 11110000aaaa0001
0 000100a8 0000000000000000 00 22220000bbbb0002
0 000180a8 0000000000000000 00 33330000cccc0003
0 000080b0 0000000000000000 00 5a5a0000000080b0
0 00040f18 0000000000000000 00 5a5a000000040f18
0 00040f38 0000000000000000 00 5a5a000000040f38
2 00040f38 0000000000000000 00 5a5a000000040f38
6 00002010 0000000000000000 00 5a5a000055667788
0 00002810 0000000000000000 00 5a5a000000002810
0 00003010 0000000000000000 00 5a5a000000003010
0 00002010 0000000000000000 00 5a5a000055667788
0 00002018 0000000000000000 00 aabbccdd00002018
ff 00000000 0000000000000000 00 0000000000000000

// ==== sources.f ====
+incdir+.
dcachePkg.sv
dataArrayIf.sv
sramBank.sv
dcacheDataArray.sv
dcacheCtrl.sv
dcacheTop.sv
tbDcache.sv
